// File: Makefile
SIM = obj_dir/ViBufferTb

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
	verilator --binary --assert -Wno-fatal --top-module iBufferTb -Mdir obj_dir -f verilog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: hdl/iBuffer.sv
`timescale 1ns/10ps
`include "ibuf_macros.svh"

module iBuffer (
    input  logic                       clk,
    input  logic                       rstN,

    // from the decoder
    input  logic                       decValid,
    input  ibufPkg::warpId_t           decWarpId,
    input  logic [31:0]                decInstr,
    input  ibufPkg::regId_t            decDst,
    input  ibufPkg::regId_t            decSrc1,
    input  ibufPkg::regId_t            decSrc2,
    input  logic                       decExit,

    // to fetch
    output logic [`IBUF_NUM_WARPS-1:0] fetchReq,

    // from the scoreboard
    input  logic [`IBUF_NUM_WARPS-1:0] depStall,

    // to/from the operand collector
    input  logic                       ocCreditReturn,
    output logic                       ocValid,
    output ibufPkg::warpId_t           ocWarpId,
    output logic [31:0]                ocInstr,
    output ibufPkg::regId_t            ocDst,
    output ibufPkg::regId_t            ocSrc1,
    output ibufPkg::regId_t            ocSrc2,

    // to retirement
    output logic                       exitValid,
    output ibufPkg::warpId_t           exitWarpId
);

    ibufPkg::ibufEntry_t        decEntry;
    ibufPkg::ibufEntry_t        headEntry [`IBUF_NUM_WARPS];
    ibufPkg::ibufEntry_t        selEntry;
    logic [`IBUF_NUM_WARPS-1:0] headValid;
    logic [`IBUF_NUM_WARPS-1:0] headExit;
    logic [`IBUF_NUM_WARPS-1:0] grant;
    ibufPkg::warpId_t           grantIdx;
    logic                       grantAny;

    assign decEntry = '{
        instr:  decInstr,
        dst:    decDst,
        src1:   decSrc1,
        src2:   decSrc2,
        isExit: decExit
    };

    //////////////////////////////////////////////////
    // per-warp FIFOs
    //////////////////////////////////////////////////

    for (genvar w = 0; w < `IBUF_NUM_WARPS; w++) begin : warpGen
        ibufWarp warp (
            .clk       (clk),
            .rstN      (rstN),
            .wrEn      (decValid && (decWarpId == ibufPkg::warpId_t'(w))),
            .wrEntry   (decEntry),
            .pop       (grant[w]),
            .headValid (headValid[w]),
            .headExit  (headExit[w]),
            .headEntry (headEntry[w]),
            .fetchReq  (fetchReq[w])
        );
    end

    issueArbiter arbiter (
        .clk            (clk),
        .rstN           (rstN),
        .headValid      (headValid),
        .headExit       (headExit),
        .depStall       (depStall),
        .ocCreditReturn (ocCreditReturn),
        .grant          (grant)
    );

    //////////////////////////////////////////////////
    // grant encode and head select
    //////////////////////////////////////////////////

    // grant is one-hot, so OR of the indices is the winner
    always_comb begin
        grantIdx = '0;
        for (int w = 0; w < `IBUF_NUM_WARPS; w++) begin
            if (grant[w]) begin
                grantIdx = grantIdx | ibufPkg::warpId_t'(w);
            end
        end
    end

    assign grantAny = |grant;
    assign selEntry = headEntry[grantIdx];

    //////////////////////////////////////////////////
    // issue registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ocValid   <= 1'b0;
            exitValid <= 1'b0;
        end else begin
            ocValid   <= grantAny && !selEntry.isExit;
            exitValid <= grantAny && selEntry.isExit;
        end
    end

    // payload only moves on a grant
    always_ff @(posedge clk) begin
        if (grantAny && !selEntry.isExit) begin
            ocWarpId <= grantIdx;
            ocInstr  <= selEntry.instr;
            ocDst    <= selEntry.dst;
            ocSrc1   <= selEntry.src1;
            ocSrc2   <= selEntry.src2;
        end
        if (grantAny && selEntry.isExit) begin
            exitWarpId <= grantIdx;
        end
    end

endmodule

// File: hdl/ibufPkg.sv
`include "ibuf_macros.svh"

package ibufPkg;

    //////////////////////////////////////////////////
    // identifiers
    //////////////////////////////////////////////////

    // warp index
    typedef logic [$clog2(`IBUF_NUM_WARPS)-1:0] warpId_t;

    // architectural register number
    typedef logic [4:0] regId_t;

    //////////////////////////////////////////////////
    // buffered instruction
    //////////////////////////////////////////////////

    // word plus three register fields and the exit flag in 48 bits
    typedef struct packed {
        logic [31:0] instr;
        regId_t      dst;
        regId_t      src1;
        regId_t      src2;
        logic        isExit;
    } ibufEntry_t;

endpackage

// File: hdl/ibufWarp.sv
`timescale 1ns/10ps
`include "ibuf_macros.svh"

module ibufWarp (
    input  logic                clk,
    input  logic                rstN,

    // write side already qualified by warp
    input  logic                wrEn,
    input  ibufPkg::ibufEntry_t wrEntry,

    // read side toward the arbiter
    input  logic                pop,
    output logic                headValid,
    output logic                headExit,
    output ibufPkg::ibufEntry_t headEntry,

    // request more work from fetch
    output logic                fetchReq
);

    localparam int ptrW = $clog2(`IBUF_DEPTH);
    localparam int cntW = $clog2(`IBUF_DEPTH + 1);

    ibufPkg::ibufEntry_t mem [`IBUF_DEPTH];

    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            exited;
    logic            full;
    logic            push;
    logic            popOk;

    // circular pointer advance
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
        logic [ptrW-1:0] n;
        if (p == ptrW'(`IBUF_DEPTH - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // status
    //////////////////////////////////////////////////

    assign full      = (count == cntW'(`IBUF_DEPTH));
    assign headValid = (count != '0);
    assign headEntry = mem[rdPtr];
    assign headExit  = headValid && headEntry.isExit;

    // writes into a full FIFO are dropped
    assign push  = wrEn && !full;
    assign popOk = pop && headValid;

    // an exited warp never asks for more instructions
    assign fetchReq = !full && !exited;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= wrEntry;
        end
    end

    //////////////////////////////////////////////////
    // pointers, count and exit state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            exited <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popOk) begin
                rdPtr <= nextPtr(rdPtr);
            end

            case ({push, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // sticky until reset
            if (popOk && headEntry.isExit) begin
                exited <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/ibuf_macros.svh
`ifndef IBUF_MACROS_SVH
`define IBUF_MACROS_SVH

//////////////////////////////////////////////////
// instruction buffer sizing
//////////////////////////////////////////////////

// warps sharing the issue stage
`define IBUF_NUM_WARPS 4

// entries held per warp
`define IBUF_DEPTH 2

// free operand collector slots out of reset
`define IBUF_OC_CREDITS 4

`endif

// File: hdl/issueArbiter.sv
`timescale 1ns/10ps
`include "ibuf_macros.svh"

module issueArbiter (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`IBUF_NUM_WARPS-1:0] headValid,
    input  logic [`IBUF_NUM_WARPS-1:0] headExit,
    input  logic [`IBUF_NUM_WARPS-1:0] depStall,
    input  logic                       ocCreditReturn,
    output logic [`IBUF_NUM_WARPS-1:0] grant
);

    localparam int creditW = $clog2(`IBUF_OC_CREDITS + 1);

    ibufPkg::warpId_t             rrPtr;
    ibufPkg::warpId_t             grantIdx;
    ibufPkg::warpId_t             nextPtr;
    logic [creditW-1:0]           creditCnt;
    logic [`IBUF_NUM_WARPS-1:0]   eligible;
    logic                         found;
    logic                         ocGrant;

    //////////////////////////////////////////////////
    // eligibility
    //////////////////////////////////////////////////

    // exits bypass the credit check
    assign eligible = headValid & ~depStall &
                      (headExit | {`IBUF_NUM_WARPS{creditCnt != '0}});

    //////////////////////////////////////////////////
    // round-robin search from the pointer
    //////////////////////////////////////////////////

    always_comb begin : pickGrant
        int idx;
        grant    = '0;
        grantIdx = '0;
        found    = 1'b0;
        for (int off = 0; off < `IBUF_NUM_WARPS; off++) begin
            idx = (int'(rrPtr) + off) % `IBUF_NUM_WARPS;
            if (!found && eligible[idx]) begin
                found       = 1'b1;
                grant[idx]  = 1'b1;
                grantIdx    = ibufPkg::warpId_t'(idx);
            end
        end
    end

    // pointer lands one past the winner
    assign nextPtr = (int'(grantIdx) == `IBUF_NUM_WARPS - 1) ?
                     '0 : grantIdx + 1'b1;

    // only ordinary issues spend a credit
    assign ocGrant = |(grant & ~headExit);

    //////////////////////////////////////////////////
    // pointer and credit state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rrPtr     <= '0;
            creditCnt <= creditW'(`IBUF_OC_CREDITS);
        end else begin
            if (found) begin
                rrPtr <= nextPtr;
            end

            // issue and return together cancel out
            case ({ocGrant, ocCreditReturn})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

endmodule

// File: verif/iBufferTb.sv
`timescale 1ns/10ps
`include "ibuf_macros.svh"

module iBufferTb;

    localparam int nW = `IBUF_NUM_WARPS;
    localparam int ocCredits = `IBUF_OC_CREDITS;
    // cycles for reset plus the six tests
    localparam int runCycles = 5 + 10 + 60 + 40 + 40 + 40;

    logic             clk = 1'b0;
    logic             rstN;
    logic             decValid;
    ibufPkg::warpId_t decWarpId;
    logic [31:0]      decInstr;
    ibufPkg::regId_t  decDst;
    ibufPkg::regId_t  decSrc1;
    ibufPkg::regId_t  decSrc2;
    logic             decExit;
    logic [nW-1:0]    depStall;
    logic             ocCreditReturn;
    logic [nW-1:0]    fetchReq;
    logic             ocValid;
    ibufPkg::warpId_t ocWarpId;
    logic [31:0]      ocInstr;
    ibufPkg::regId_t  ocDst;
    ibufPkg::regId_t  ocSrc1;
    ibufPkg::regId_t  ocSrc2;
    logic             exitValid;
    ibufPkg::warpId_t exitWarpId;

    // record layout is warp, instr, dst, src1, src2
    logic [48:0] expQ [nW][$];
    logic [48:0] ocSeen [$];
    int          exitSeen [$];
    logic [48:0] lastRec;
    int          errCount = 0;
    int          testsFailed = 0;
    int          modelCredits = ocCredits;
    int          modelPtr = 0;

    iBuffer dut (.*);

    always #50 clk = ~clk;

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (ocValid)
                ocSeen.push_back({ocWarpId, ocInstr, ocDst, ocSrc1, ocSrc2});
            if (exitValid)
                exitSeen.push_back(int'(exitWarpId));
        end
    end

    initial begin
        #(2 * runCycles * 100);
        $display("Error: watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////

    task automatic tick(input int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed", name);
            testsFailed++;
        end
    endtask

    // waits for fetchReq, then offers one random instruction
    task automatic sendInstr(input int w, input bit isExit);
        int waited;
        waited = 0;
        while (!fetchReq[w] && waited < 20) begin
            tick();
            waited++;
        end
        if (!fetchReq[w]) begin
            $display("Error: warp %0d never requested fetch", w);
            errCount++;
        end
        decWarpId = ibufPkg::warpId_t'(w);
        decInstr  = $urandom();
        decDst    = ibufPkg::regId_t'($urandom());
        decSrc1   = ibufPkg::regId_t'($urandom());
        decSrc2   = ibufPkg::regId_t'($urandom());
        decExit   = isExit;
        decValid  = 1'b1;
        lastRec   = {decWarpId, decInstr, decDst, decSrc1, decSrc2};
        if (!isExit)
            expQ[w].push_back(lastRec);
        tick();
        decValid = 1'b0;
        decExit  = 1'b0;
    endtask

    task automatic returnCredits(input int n);
        if (n > 0) begin
            ocCreditReturn = 1'b1;
            tick(n);
            ocCreditReturn = 1'b0;
            modelCredits += n;
        end
    endtask

    task automatic waitIssued(input bit exitPort, input int n);
        int waited;
        waited = 0;
        while ((exitPort ? exitSeen.size() : ocSeen.size()) < n && waited < 20) begin
            tick();
            waited++;
        end
        if ((exitPort ? exitSeen.size() : ocSeen.size()) < n) begin
            $display("Error: timed out waiting for %0d issues at %0t", n, $time);
            errCount++;
        end
    endtask

    // compare observed issues with the per-warp queues
    task automatic drainIssues(input int stalledWarp);
        logic [48:0] rec;
        int          w;
        while (ocSeen.size() > 0) begin
            rec = ocSeen.pop_front();
            w = int'(rec[48:47]);
            modelCredits--;
            modelPtr = (w + 1) % nW;
            if (w == stalledWarp) begin
                $display("Error: warp %0d issued while its dependency stall was set", w);
                errCount++;
            end
            if (expQ[w].size() == 0) begin
                $display("Error: warp %0d issued with nothing buffered", w);
                errCount++;
            end else begin
                checkEq("ocIssue", rec, expQ[w].pop_front());
            end
        end
    endtask

    ////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////

    task automatic testReset();
        int e;
        e = errCount;
        checkEq("ocValid", ocValid, 0);
        checkEq("exitValid", exitValid, 0);
        checkEq("fetchReq", fetchReq, {nW{1'b1}});
        reportTest("reset", e);
    endtask

    task automatic testSingle();
        int e;
        e = errCount;
        sendInstr(2, 1'b0);
        checkEq("ocValid", ocValid, 0);
        tick();
        checkEq("ocValid", ocValid, 1);
        checkEq("ocWarpId", ocWarpId, 2);
        checkEq("ocFields", {ocWarpId, ocInstr, ocDst, ocSrc1, ocSrc2}, lastRec);
        tick();
        drainIssues(-1);
        returnCredits(ocCredits - modelCredits);
        reportTest("single", e);
    endtask

    task automatic testBackPressure();
        int e;
        e = errCount;
        for (int i = 0; i < 8; i++)
            sendInstr(i % nW, 1'b0);
        waitIssued(1'b0, ocCredits);
        tick(6);
        checkEq("issueCount", ocSeen.size(), ocCredits);
        // each returned credit lets exactly one more through
        for (int k = 1; k <= 8 - ocCredits; k++) begin
            returnCredits(1);
            waitIssued(1'b0, ocCredits + k);
            tick(3);
            checkEq("issueCount", ocSeen.size(), ocCredits + k);
        end
        drainIssues(-1);
        returnCredits(ocCredits - modelCredits);
        reportTest("backPressure", e);
    endtask

    task automatic testRoundRobin();
        int e;
        int start;
        e = errCount;
        // hold all warps so every FIFO fills before arbitration
        depStall = '1;
        for (int i = 0; i < 2 * nW; i++)
            sendInstr(i % nW, 1'b0);
        start = modelPtr;
        depStall = '0;
        waitIssued(1'b0, ocCredits);
        returnCredits(2 * nW - ocCredits);
        waitIssued(1'b0, 2 * nW);
        for (int i = 0; i < ocSeen.size(); i++)
            checkEq("issueWarp", ocSeen[i][48:47], (start + i) % nW);
        drainIssues(-1);
        returnCredits(ocCredits - modelCredits);
        reportTest("roundRobin", e);
    endtask

    task automatic testDepStall();
        int e;
        e = errCount;
        depStall = 4'b0010;
        sendInstr(1, 1'b0);
        sendInstr(1, 1'b0);
        sendInstr(0, 1'b0);
        sendInstr(2, 1'b0);
        sendInstr(3, 1'b0);
        waitIssued(1'b0, 3);
        tick(4);
        checkEq("issueCount", ocSeen.size(), 3);
        drainIssues(1);
        returnCredits(ocCredits - modelCredits);
        depStall = '0;
        waitIssued(1'b0, 2);
        tick(2);
        checkEq("issueCount", ocSeen.size(), 2);
        drainIssues(-1);
        returnCredits(ocCredits - modelCredits);
        reportTest("depStall", e);
    endtask

    task automatic testExit();
        int e;
        e = errCount;
        // use up every credit first
        sendInstr(0, 1'b0);
        sendInstr(0, 1'b0);
        sendInstr(2, 1'b0);
        sendInstr(2, 1'b0);
        waitIssued(1'b0, ocCredits);
        drainIssues(-1);
        checkEq("modelCredits", modelCredits, 0);
        sendInstr(3, 1'b1);
        waitIssued(1'b1, 1);
        if (exitSeen.size() > 0) begin
            checkEq("exitWarpId", exitSeen.pop_front(), 3);
            modelPtr = 0;
        end
        checkEq("ocIssueCount", ocSeen.size(), 0);
        checkEq("fetchReq", fetchReq, 4'b0111);
        returnCredits(ocCredits - modelCredits);
        reportTest("exit", e);
    endtask

    initial begin
        void'($urandom(59));
        rstN           = 1'b0;
        decValid       = 1'b0;
        decWarpId      = '0;
        decInstr       = '0;
        decDst         = '0;
        decSrc1        = '0;
        decSrc2        = '0;
        decExit        = 1'b0;
        depStall       = '0;
        ocCreditReturn = 1'b0;
        tick(2);
        rstN = 1'b1;

        testReset();
        testSingle();
        testBackPressure();
        testRoundRobin();
        testDepStall();
        testExit();

        for (int w = 0; w < nW; w++)
            checkEq("expQueueLeft", expQ[w].size(), 0);
        $display("tests run: 6, tests failed: %0d, errors: %0d", testsFailed, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/iBuffer_checker.sv
`timescale 1ns/10ps
`include "ibuf_macros.svh"

module iBufferChecker (
    input logic                                   clk,
    input logic                                   rstN,
    input logic                                   ocValid,
    input logic                                   exitValid,
    input logic                                   ocCreditReturn,
    input logic [`IBUF_NUM_WARPS-1:0]             grant,
    input logic [$clog2(`IBUF_OC_CREDITS + 1)-1:0] creditCnt
);

    // one issue per cycle on one port only
    dualIssue: assert property (@(posedge clk) disable iff (!rstN) !(ocValid && exitValid))
        else $error("collector and exit outputs valid in the same cycle");

    // at most one warp wins
    grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
        else $error("issue grant has more than one bit set");

    // counter stays within the collector's slots
    creditCeiling: assert property (@(posedge clk) disable iff (!rstN)
        creditCnt <= `IBUF_OC_CREDITS)
        else $error("credit count above the collector capacity");

    // count follows collector issues and returns without wrapping below zero
    creditTrack: assert property (@(posedge clk) disable iff (!rstN)
        int'(creditCnt) ==
        int'($past(creditCnt)) + int'($past(ocCreditReturn)) - int'(ocValid))
        else $error("credit count does not follow issues and returns");

endmodule

bind iBuffer iBufferChecker issueChk (
    .clk            (clk),
    .rstN           (rstN),
    .ocValid        (ocValid),
    .exitValid      (exitValid),
    .ocCreditReturn (ocCreditReturn),
    .grant          (grant),
    .creditCnt      (arbiter.creditCnt)
);

// File: verilog.f
+incdir+hdl
hdl/ibufPkg.sv
hdl/ibufWarp.sv
hdl/issueArbiter.sv
hdl/iBuffer.sv
verif/iBuffer_checker.sv
verif/iBufferTb.sv
